// File: keypad_calc_consts.svh
`ifndef KEYPAD_CALC_CONSTS_SVH
`define KEYPAD_CALC_CONSTS_SVH

// scanner
`define KC_DEBOUNCE     8       // stable scan cycles for press or release

// datapath widths
`define KC_DATA_W       16      // operand, result and apb data
`define KC_ADDR_W       4       // apb byte address

// operator codes as carried on key_op
`define KC_OP_NONE      3'd0
`define KC_OP_NEG       3'd1    // sign change, acts on entry only
`define KC_OP_ADD       3'd2
`define KC_OP_SUB       3'd3
`define KC_OP_MUL       3'd4

// apb register offsets
`define KC_ADDR_STATUS  4'd0    // bit 0 result_ready, bit 1 overrun
`define KC_ADDR_RESULT  4'd4
`define KC_ADDR_ENTRY   4'd8
`define KC_ADDR_COUNT   4'd12

`endif

// File: keypad_calc_pkg.sv
`include "keypad_calc_consts.svh"

package keypad_calc_pkg;

    // keypad position, row * 4 + column
    typedef logic [3:0] key_idx_t;

    // single decimal digit 0..9
    typedef logic [3:0] digit_t;

    // operator code, see KC_OP_* defines
    typedef logic [2:0] op_t;

    // two's complement operand / result, wraps
    typedef logic [`KC_DATA_W-1:0] value_t;

    // apb side
    typedef logic [`KC_ADDR_W-1:0] apb_addr_t;
    typedef logic [`KC_DATA_W-1:0] apb_data_t;

    // scanner fsm
    typedef enum logic [1:0] {
        SCAN,       // walk columns
        DEBOUNCE,   // column frozen, count stable cycles
        HOLD,       // event up, waiting for ack
        RELEASE     // wait for all rows high
    } scan_state_e;

endpackage

// File: keypad_scanner.sv
`timescale 1ns/1ns
`include "keypad_calc_consts.svh"

module keypad_scanner (
    input  logic                    clk,
    input  logic                    nRST,
    input  logic [3:0]              row_in,         // pulled up, low when pressed
    input  logic                    key_ack,        // one-cycle pulse from core
    output logic [3:0]              col_out,        // exactly one column low
    output logic                    key_valid,      // held until key_ack
    output keypad_calc_pkg::digit_t key_digit,
    output keypad_calc_pkg::op_t    key_op,
    output logic                    key_is_digit,
    output logic                    key_is_equal
);

    keypad_calc_pkg::scan_state_e state;
    logic [1:0]                   col;              // current column index
    logic [3:0]                   dbnc_cnt;         // stable cycle count
    logic                         row_low;          // some row pulled low
    logic [1:0]                   row_sel;          // lowest low row
    keypad_calc_pkg::key_idx_t    cur_idx;          // position seen now
    keypad_calc_pkg::key_idx_t    cand_idx;         // position under debounce
    logic                         same_key;
    logic                         dbnc_done;

    // decoded view of cand_idx
    keypad_calc_pkg::digit_t      dec_digit;
    keypad_calc_pkg::op_t         dec_op;
    logic                         dec_is_digit;
    logic                         dec_is_equal;
    logic                         dec_unused;

    always_comb begin
        col_out      = 4'b1111;
        col_out[col] = 1'b0;                        // active column driven low
    end

    // lowest row wins on multi-key
    always_comb begin
        row_low = ~&row_in;
        casez (row_in)
            4'b???0: row_sel = 2'd0;
            4'b??01: row_sel = 2'd1;
            4'b?011: row_sel = 2'd2;
            4'b0111: row_sel = 2'd3;
            default: row_sel = 2'd0;                // nothing pressed
        endcase
    end

    assign cur_idx   = {row_sel, col};              // row * 4 + col
    assign same_key  = row_low && (cur_idx == cand_idx);
    assign dbnc_done = (dbnc_cnt == 4'(`KC_DEBOUNCE - 1));

    // keypad map
    always_comb begin
        case (cand_idx)
            4'd0, 4'd1, 4'd2:  dec_digit = cand_idx + 4'd1;  // 1..3
            4'd4, 4'd5, 4'd6:  dec_digit = cand_idx;         // 4..6
            4'd8, 4'd9, 4'd10: dec_digit = cand_idx - 4'd1;  // 7..9
            default:           dec_digit = 4'd0;             // 13 is zero too
        endcase
        case (cand_idx)
            4'd3:    dec_op = `KC_OP_ADD;
            4'd7:    dec_op = `KC_OP_SUB;
            4'd11:   dec_op = `KC_OP_MUL;
            4'd15:   dec_op = `KC_OP_NEG;
            default: dec_op = `KC_OP_NONE;
        endcase
        dec_is_digit = ((cand_idx[1:0] != 2'd3) && (cand_idx < 4'd12)) || (cand_idx == 4'd13);
        dec_is_equal = (cand_idx == 4'd12);
        dec_unused   = (cand_idx == 4'd14);         // blank key, no event
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state     <= keypad_calc_pkg::SCAN;
            col       <= 2'd0;
            dbnc_cnt  <= 4'd0;
            cand_idx  <= '0;
            key_valid <= 1'b0;
        end else begin
            case (state)
                keypad_calc_pkg::SCAN: begin
                    if (row_low) begin
                        cand_idx <= cur_idx;        // freeze column here
                        dbnc_cnt <= 4'd1;           // first stable cycle
                        state    <= keypad_calc_pkg::DEBOUNCE;
                    end else begin
                        col <= col + 2'd1;          // wraps 3 -> 0
                    end
                end
                keypad_calc_pkg::DEBOUNCE: begin
                    if (!same_key) begin
                        dbnc_cnt <= 4'd0;           // bounce, resume scan
                        state    <= keypad_calc_pkg::SCAN;
                    end else if (dbnc_done) begin
                        dbnc_cnt <= 4'd0;
                        if (dec_unused) begin
                            state <= keypad_calc_pkg::RELEASE;
                        end else begin
                            key_valid <= 1'b1;
                            state     <= keypad_calc_pkg::HOLD;
                        end
                    end else begin
                        dbnc_cnt <= dbnc_cnt + 4'd1;
                    end
                end
                keypad_calc_pkg::HOLD: begin
                    if (key_ack) begin
                        key_valid <= 1'b0;          // drops cycle after ack
                        state     <= keypad_calc_pkg::RELEASE;
                    end
                end
                keypad_calc_pkg::RELEASE: begin
                    if (row_low) begin
                        dbnc_cnt <= 4'd0;           // still held or bouncing
                    end else if (dbnc_done) begin
                        dbnc_cnt <= 4'd0;
                        state    <= keypad_calc_pkg::SCAN;
                    end else begin
                        dbnc_cnt <= dbnc_cnt + 4'd1;
                    end
                end
                default: state <= keypad_calc_pkg::SCAN;
            endcase
        end
    end

    // event fields, loaded once per accepted press
    always_ff @(posedge clk) begin
        if (state == keypad_calc_pkg::DEBOUNCE && same_key && dbnc_done) begin
            key_digit    <= dec_digit;
            key_op       <= dec_op;
            key_is_digit <= dec_is_digit;
            key_is_equal <= dec_is_equal;
        end
    end

endmodule

// File: calc_core.sv
`timescale 1ns/1ns
`include "keypad_calc_consts.svh"

module calc_core (
    input  logic                    clk,
    input  logic                    nRST,
    input  logic                    key_valid,      // from scanner
    input  keypad_calc_pkg::digit_t key_digit,
    input  keypad_calc_pkg::op_t    key_op,
    input  logic                    key_is_digit,
    input  logic                    key_is_equal,
    output logic                    key_ack,        // one-cycle pulse
    output keypad_calc_pkg::value_t entry_value,    // live entry
    output logic                    res_valid,      // one-cycle pulse
    output keypad_calc_pkg::value_t res_value
);

    keypad_calc_pkg::value_t acc;                   // running left operand
    keypad_calc_pkg::op_t    pend;                  // operator waiting for entry
    keypad_calc_pkg::value_t eval;                  // pend applied to acc, entry
    keypad_calc_pkg::value_t entry_shift;           // entry * 10 + digit
    logic                    take_key;

    // all results truncate to 16 bits, so wrap comes for free
    function automatic keypad_calc_pkg::value_t apply_op(
        input keypad_calc_pkg::op_t   op,
        input keypad_calc_pkg::value_t a,
        input keypad_calc_pkg::value_t b
    );
        case (op)
            `KC_OP_ADD: return a + b;
            `KC_OP_SUB: return a - b;
            `KC_OP_MUL: return a * b;
            default:    return b;                   // nothing pending
        endcase
    endfunction

    assign eval        = apply_op(pend, acc, entry_value);
    assign entry_shift = keypad_calc_pkg::value_t'(entry_value * 16'd10)
                       + keypad_calc_pkg::value_t'(key_digit);
    assign take_key    = key_ack;                   // fields still stable here

    // ack the cycle after valid, never twice for one event
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            key_ack <= 1'b0;
        end else begin
            key_ack <= key_valid && !key_ack;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            entry_value <= '0;
            acc         <= '0;
            pend        <= `KC_OP_NONE;
            res_valid   <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            if (take_key) begin
                if (key_is_digit) begin
                    entry_value <= entry_shift;
                end else if (key_is_equal) begin
                    res_valid   <= 1'b1;        // result out next cycle
                    acc         <= '0;
                    pend        <= `KC_OP_NONE;
                    entry_value <= '0;
                end else if (key_op == `KC_OP_NEG) begin
                    entry_value <= -entry_value;    // sign change on entry
                end else if (key_op != `KC_OP_NONE) begin
                    acc         <= eval;            // fold pending op
                    pend        <= key_op;
                    entry_value <= '0;
                end
            end
        end
    end

    // result payload, qualified by res_valid
    always_ff @(posedge clk) begin
        if (take_key && key_is_equal) begin
            res_value <= eval;
        end
    end

endmodule

// File: calc_apb_regs.sv
`timescale 1ns/1ns
`include "keypad_calc_consts.svh"

module calc_apb_regs (
    input  logic                       clk,
    input  logic                       nRST,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  keypad_calc_pkg::apb_addr_t paddr,
    input  keypad_calc_pkg::apb_data_t pwdata,      // content ignored, status write clears
    input  keypad_calc_pkg::value_t    entry_value,
    input  logic                       res_valid,
    input  keypad_calc_pkg::value_t    res_value,
    output keypad_calc_pkg::apb_data_t prdata,
    output logic                       pready,
    output logic                       pslverr
);

    keypad_calc_pkg::value_t    result_q;           // last result
    keypad_calc_pkg::apb_data_t res_count;          // wraps at 16 bits
    logic                       result_ready;
    logic                       overrun;
    logic                       access;             // apb access phase
    logic                       rd_access;
    logic                       wr_access;
    logic                       rd_result;
    logic                       wr_status;
    logic                       addr_hit;

    assign pready    = 1'b1;                        // zero wait states
    assign access    = psel && penable;
    assign rd_access = access && !pwrite;
    assign wr_access = access && pwrite;
    assign rd_result = rd_access && (paddr == `KC_ADDR_RESULT);
    assign wr_status = wr_access && (paddr == `KC_ADDR_STATUS);

    always_comb begin
        addr_hit = 1'b1;
        case (paddr)
            `KC_ADDR_STATUS: prdata = keypad_calc_pkg::apb_data_t'({overrun, result_ready});
            `KC_ADDR_RESULT: prdata = result_q;
            `KC_ADDR_ENTRY:  prdata = entry_value;
            `KC_ADDR_COUNT:  prdata = res_count;
            default: begin
                prdata   = '0;                      // unmapped reads zero
                addr_hit = 1'b0;
            end
        endcase
    end

    // read-only map, status write is the one legal write
    assign pslverr = (rd_access && !addr_hit) || (wr_access && !wr_status);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            result_q     <= '0;
            res_count    <= '0;
            result_ready <= 1'b0;
            overrun      <= 1'b0;
        end else begin
            if (res_valid) begin
                result_q  <= res_value;
                res_count <= res_count + 16'd1;
            end
            // new result wins over a same-cycle read
            result_ready <= res_valid || (result_ready && !rd_result);
            // unread result overwritten, set beats clear
            overrun <= (res_valid && result_ready && !rd_result) || (overrun && !wr_status);
        end
    end

endmodule

// File: keypad_calc.sv
`timescale 1ns/1ns

module keypad_calc (
    input  logic                       clk,
    input  logic                       nRST,
    input  logic [3:0]                 row_in,      // keypad rows, pulled up
    output logic [3:0]                 col_out,     // keypad columns
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  keypad_calc_pkg::apb_addr_t paddr,
    input  keypad_calc_pkg::apb_data_t pwdata,
    output keypad_calc_pkg::apb_data_t prdata,
    output logic                       pready,
    output logic                       pslverr
);

    // scanner -> core key event
    logic                    key_valid;
    logic                    key_ack;
    keypad_calc_pkg::digit_t key_digit;
    keypad_calc_pkg::op_t    key_op;
    logic                    key_is_digit;
    logic                    key_is_equal;

    // core -> registers
    keypad_calc_pkg::value_t entry_value;
    logic                    res_valid;
    keypad_calc_pkg::value_t res_value;

    keypad_scanner keypad_scanner_inst (
        .clk          (clk),
        .nRST         (nRST),
        .row_in       (row_in),
        .key_ack      (key_ack),
        .col_out      (col_out),
        .key_valid    (key_valid),
        .key_digit    (key_digit),
        .key_op       (key_op),
        .key_is_digit (key_is_digit),
        .key_is_equal (key_is_equal)
    );

    calc_core calc_core_inst (
        .clk          (clk),
        .nRST         (nRST),
        .key_valid    (key_valid),
        .key_digit    (key_digit),
        .key_op       (key_op),
        .key_is_digit (key_is_digit),
        .key_is_equal (key_is_equal),
        .key_ack      (key_ack),
        .entry_value  (entry_value),
        .res_valid    (res_valid),
        .res_value    (res_value)
    );

    calc_apb_regs calc_apb_regs_inst (
        .clk          (clk),
        .nRST         (nRST),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .entry_value  (entry_value),
        .res_valid    (res_valid),
        .res_value    (res_value),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr)
    );

endmodule

// File: keypad_calc_props.sv
`timescale 1ns/1ns

module keypad_calc_props (
    input  logic                    clk,
    input  logic                    nRST,
    input  logic                    key_valid,
    input  logic                    key_ack,
    input  keypad_calc_pkg::digit_t key_digit,
    input  keypad_calc_pkg::op_t    key_op,
    input  logic                    key_is_digit,
    input  logic                    key_is_equal,
    input  logic                    res_valid,
    input  logic                    psel,
    input  logic                    penable,
    input  logic [3:0]              col_out
);

    // event stays up, fields frozen, until the core acks
    key_hold_a: assert property (@(posedge clk) disable iff (!nRST)
        key_valid && !key_ack |=> key_valid
            && $stable({key_digit, key_op, key_is_digit, key_is_equal}))
        else $error("key event dropped or changed before ack");

    res_pulse_a: assert property (@(posedge clk) disable iff (!nRST)
        res_valid |=> !res_valid)                   // single-cycle result strobe
        else $error("res_valid held longer than one cycle");

    apb_phase_a: assert property (@(posedge clk) disable iff (!nRST)
        psel && !penable |=> psel && penable)       // setup always followed by access
        else $error("apb setup phase not followed by access phase");

    col_a: assert property (@(posedge clk) disable iff (!nRST)
        key_valid |=> $stable(col_out))             // column frozen while event is up
        else $error("col_out moved while a key event waited for ack");

endmodule

bind keypad_calc keypad_calc_props keypad_calc_props_inst (
    .clk          (clk),
    .nRST         (nRST),
    .key_valid    (key_valid),
    .key_ack      (key_ack),
    .key_digit    (key_digit),
    .key_op       (key_op),
    .key_is_digit (key_is_digit),
    .key_is_equal (key_is_equal),
    .res_valid    (res_valid),
    .psel         (psel),
    .penable      (penable),
    .col_out      (col_out)
);

// File: tb_keypad_calc.sv
`timescale 1ns/1ns
`include "keypad_calc_consts.svh"

module tb_keypad_calc;

    localparam int MAX_KEYS  = 116;                 // most presses the sequence below can make
    localparam int CYC_LIMIT = MAX_KEYS * 100 + 2000;
    localparam int HOLD_CYC  = 40;                  // press length and release gap

    logic                       clk;
    logic                       nRST;
    logic [3:0]                 row_in;
    logic [3:0]                 col_out;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    keypad_calc_pkg::apb_addr_t paddr;
    keypad_calc_pkg::apb_data_t pwdata;
    keypad_calc_pkg::apb_data_t prdata;
    logic                       pready;
    logic                       pslverr;

    logic                       pressing;           // a key is held down
    keypad_calc_pkg::key_idx_t  press_idx;          // which one
    int                         cycles = 0;

    // reference calculator
    keypad_calc_pkg::value_t    m_entry;
    keypad_calc_pkg::value_t    m_acc;
    keypad_calc_pkg::value_t    m_result;
    keypad_calc_pkg::value_t    m_count;
    keypad_calc_pkg::op_t       m_pend;
    logic                       m_ready;
    logic                       m_overrun;

    // digit per keypad position, -1 where the key is not a digit
    int digit_of [16] = '{1, 2, 3, -1, 4, 5, 6, -1, 7, 8, 9, -1, -1, 0, -1, -1};
    keypad_calc_pkg::key_idx_t op_keys [3] = '{4'd3, 4'd7, 4'd11};  // add, sub, mul

    keypad_calc keypad_calc_inst (
        .clk     (clk),
        .nRST    (nRST),
        .row_in  (row_in),
        .col_out (col_out),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // passive switch matrix, row follows the selected column
    assign row_in = (pressing && !col_out[press_idx[1:0]]) ? ~(4'b0001 << press_idx[3:2])
                                                          : 4'b1111;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYC_LIMIT) begin
            abort_run("timeout, the run did not finish within its cycle budget");
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input keypad_calc_pkg::value_t got,
                               input keypad_calc_pkg::value_t exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp));
        end
    endtask

    task automatic check_cols(input string name, input logic [3:0] got,
                              input logic [3:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp));
        end
    endtask

    function automatic keypad_calc_pkg::value_t model_op(input keypad_calc_pkg::op_t op,
            input keypad_calc_pkg::value_t a, input keypad_calc_pkg::value_t b);
        int r;
        case (op)
            `KC_OP_ADD: r = int'($signed(a)) + int'($signed(b));
            `KC_OP_SUB: r = int'($signed(a)) - int'($signed(b));
            `KC_OP_MUL: r = int'($signed(a)) * int'($signed(b));
            default:    r = int'($signed(b));       // no pending op, entry alone
        endcase
        return keypad_calc_pkg::value_t'(r);        // low 16 bits, wrap
    endfunction

    function automatic keypad_calc_pkg::value_t expected_reg(input keypad_calc_pkg::apb_addr_t a);
        case (a)
            `KC_ADDR_STATUS: return keypad_calc_pkg::value_t'({m_overrun, m_ready});
            `KC_ADDR_RESULT: return m_result;
            `KC_ADDR_ENTRY:  return m_entry;
            `KC_ADDR_COUNT:  return m_count;
            default:         return '0;
        endcase
    endfunction

    function automatic keypad_calc_pkg::key_idx_t random_digit_key();
        keypad_calc_pkg::key_idx_t idx;
        do begin
            idx = 4'($urandom_range(15, 0));
        end while (digit_of[idx] < 0);
        return idx;
    endfunction

    // reference update for one accepted key
    task automatic model_key(input keypad_calc_pkg::key_idx_t idx);
        if (digit_of[idx] >= 0) begin
            m_entry = keypad_calc_pkg::value_t'(m_entry * 10 + digit_of[idx]);
        end else if (idx == 4'd15) begin
            m_entry = -m_entry;                     // sign change
        end else if (idx == 4'd12) begin
            if (m_ready) m_overrun = 1'b1;          // previous result never read
            m_result = model_op(m_pend, m_acc, m_entry);
            m_ready  = 1'b1;
            m_count  = m_count + 16'd1;
            m_acc    = '0;
            m_pend   = `KC_OP_NONE;
            m_entry  = '0;
        end else if (idx != 4'd14) begin
            m_acc   = model_op(m_pend, m_acc, m_entry);
            m_pend  = (idx == 4'd3) ? `KC_OP_ADD : (idx == 4'd7) ? `KC_OP_SUB : `KC_OP_MUL;
            m_entry = '0;
        end
    endtask

    // short holds are bounces, the model ignores them
    task automatic press_key(input keypad_calc_pkg::key_idx_t idx, input int hold);
        @(posedge clk);
        press_idx <= idx;
        pressing  <= 1'b1;
        repeat (hold) @(posedge clk);
        pressing <= 1'b0;
        repeat (HOLD_CYC) @(posedge clk);
        if (hold >= HOLD_CYC) model_key(idx);
    endtask

    task automatic apb_transfer(input logic write, input keypad_calc_pkg::apb_addr_t addr,
                                input keypad_calc_pkg::apb_data_t wdata,
                                output keypad_calc_pkg::apb_data_t rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;                            // setup phase
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;                            // access phase
        @(negedge clk);
        rdata = prdata;                             // mid-cycle, settled
        err   = pslverr;
        check_bit("pready", pready, 1'b1);          // no wait states
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_check(input keypad_calc_pkg::apb_addr_t addr, input string name);
        keypad_calc_pkg::apb_data_t data;
        logic                       err;
        apb_transfer(1'b0, addr, '0, data, err);
        check_bit({name, " pslverr"}, err, 1'b0);
        check_value(name, data, expected_reg(addr));
        if (addr == `KC_ADDR_RESULT) m_ready = 1'b0;   // completed read clears ready
    endtask

    task automatic enter_chain(input int operands);
        int ndig;
        for (int i = 0; i < operands; i++) begin
            ndig = $urandom_range(3, 1);
            repeat (ndig) press_key(random_digit_key(), HOLD_CYC);
            if ($urandom_range(3, 0) == 0) press_key(4'd15, HOLD_CYC);     // negate now and then
            if (i < operands - 1) press_key(op_keys[$urandom_range(2, 0)], HOLD_CYC);
        end
        press_key(4'd12, HOLD_CYC);                 // equal
    endtask

    initial begin
        keypad_calc_pkg::apb_data_t data;
        logic                       err;
        void'($urandom(32'h10baf2d5));
        nRST      = 1'b0;
        pressing  = 1'b0;
        press_idx = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        m_entry   = '0;
        m_acc     = '0;
        m_result  = '0;
        m_count   = '0;
        m_pend    = `KC_OP_NONE;
        m_ready   = 1'b0;
        m_overrun = 1'b0;
        repeat (4) @(posedge clk);
        check_cols("col_out", col_out, 4'b1110);    // column 0 selected in reset
        nRST <= 1'b1;

        // all registers zero out of reset
        read_check(`KC_ADDR_STATUS, "status");
        read_check(`KC_ADDR_RESULT, "result");
        read_check(`KC_ADDR_ENTRY, "entry");
        read_check(`KC_ADDR_COUNT, "count");

        // digit entry, long enough to wrap
        repeat (6) begin
            press_key(random_digit_key(), HOLD_CYC);
            read_check(`KC_ADDR_ENTRY, "entry");
        end
        press_key(4'd15, HOLD_CYC);
        read_check(`KC_ADDR_ENTRY, "entry");
        press_key(random_digit_key(), HOLD_CYC);
        read_check(`KC_ADDR_ENTRY, "entry");
        press_key(4'd12, HOLD_CYC);
        read_check(`KC_ADDR_RESULT, "result");

        // random expressions
        repeat (4) begin
            enter_chain($urandom_range(4, 2));
            read_check(`KC_ADDR_STATUS, "status");  // ready expected set
            read_check(`KC_ADDR_RESULT, "result");
            read_check(`KC_ADDR_STATUS, "status");  // and clear again
            read_check(`KC_ADDR_COUNT, "count");
        end

        // two results, no read in between
        enter_chain(2);
        enter_chain(2);
        read_check(`KC_ADDR_STATUS, "status");
        read_check(`KC_ADDR_RESULT, "result");
        apb_transfer(1'b1, `KC_ADDR_STATUS, 16'($urandom), data, err);
        check_bit("status write pslverr", err, 1'b0);
        m_overrun = 1'b0;
        read_check(`KC_ADDR_STATUS, "status");

        // bounces and the blank key
        press_key(random_digit_key(), HOLD_CYC);
        press_key(random_digit_key(), HOLD_CYC);
        repeat (4) begin
            press_key(random_digit_key(), $urandom_range(`KC_DEBOUNCE - 1, 1));
            read_check(`KC_ADDR_ENTRY, "entry");
        end
        press_key(4'd14, HOLD_CYC);
        read_check(`KC_ADDR_ENTRY, "entry");

        // slave errors
        apb_transfer(1'b0, 4'(($urandom_range(3, 0) << 2) | $urandom_range(3, 1)), '0, data, err);
        check_bit("unmapped pslverr", err, 1'b1);
        check_value("unmapped prdata", data, '0);
        apb_transfer(1'b1, `KC_ADDR_RESULT, 16'($urandom), data, err);
        check_bit("result write pslverr", err, 1'b1);
        read_check(`KC_ADDR_RESULT, "result");
        read_check(`KC_ADDR_COUNT, "count");

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: keypad_calc.f
+incdir+.
keypad_calc_pkg.sv
keypad_scanner.sv
calc_core.sv
calc_apb_regs.sv
keypad_calc.sv
keypad_calc_props.sv
tb_keypad_calc.sv
